// ==== Makefile ====
SIM      ?= verilator
TOP      ?= issuer_tb
FILELIST ?= filelist.f
VFLAGS   ?= --binary --timing --assert -Wno-fatal -j 0

OBJDIR   := obj_dir
BIN      := $(OBJDIR)/V$(TOP)
SOURCES  := $(wildcard verilog/*.sv tb/*.sv tb/*.svh)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR) -o V$(TOP)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "Result: PASSED"

clean:
	rm -rf $(OBJDIR)

// ==== filelist.f ====
+incdir+tb
verilog/reg_pkg.sv
verilog/issue_pkg.sv
verilog/pipe_select.sv
verilog/reg_reserve.sv
verilog/operand_fwd.sv
verilog/issuer.sv
tb/issuer_tb.sv

// ==== tb/issuer_tests.svh ====
/*
 * Directed test tasks for the issue stage, included into the testbench
 * module. Each task drives the slots, checks the response and leaves
 * the reservation scoreboard empty.
 */

task automatic test_single_issue();
  // older instruction sits in slot b
  next_cycle();
  idle_inputs();
  set_slot(1'b0, PL_ALU, 5'd1, 5'd2, 2'b11, 5'd5, 1'b1, 32'h0000_0100);
  ira_is0  = 1'b0;
  ir_valid = 2'b01;
  sample();
  check(issuer_rdy == 2'b01 && ex_valid == pipe_bit(PlAlu1), "slot b alu not issued to ALU1");
  check(sbd_wr_valid == 2'b01 && sbd_wdata0_pc == 32'h0000_0100 &&
        sbd_wdata0_pl == pipe_bit(PlAlu1), "commit fifo slot 0 wrong for alu");
  next_cycle();
  idle_inputs();
  set_slot(1'b1, PL_BRANCH, 5'd3, 5'd4, 2'b11, 5'd0, 1'b0, 32'h0000_0104);
  ir_valid = 2'b01;
  sample();
  check(issuer_rdy == 2'b01 && ex_valid == pipe_bit(PlBranch), "branch not issued");
  check(sbd_wr_valid == 2'b00, "branch written to the commit fifo");
  flush_all();
endtask

task automatic test_pair_rules();
  next_cycle();
  idle_inputs();
  set_slot(1'b1, PL_LS, 5'd6, 5'd0, 2'b01, 5'd0, 1'b0, 32'h0000_0200);
  set_slot(1'b0, PL_LS, 5'd7, 5'd0, 2'b01, 5'd0, 1'b0, 32'h0000_0204);
  ir_valid = 2'b11;
  sample();
  check(issuer_rdy == 2'b01 && ex_valid == pipe_bit(PlLs), "two ls did not issue singly");
  next_cycle();
  set_slot(1'b0, PL_MULT, 5'd8, 5'd9, 2'b11, 5'd10, 1'b1, 32'h0000_020c);
  sample();
  check(issuer_rdy == 2'b11 && ex_valid == (pipe_bit(PlLs) | pipe_bit(PlMult)),
        "ls and mult not issued together");
  check(sbd_wr_valid == 2'b11 && sbd_wdata0_pc == 32'h0000_0200 &&
        sbd_wdata1_pc == 32'h0000_020c, "commit fifo wrong for ls and mult");
  check(sbd_wdata0_pl == pipe_bit(PlLs) && sbd_wdata1_pl == pipe_bit(PlMult),
        "commit fifo pipe selection wrong for ls and mult");
  next_cycle();
  set_slot(1'b1, PL_JALR, 5'd2, 5'd0, 2'b01, 5'd1, 1'b1, 32'h0000_0210);
  set_slot(1'b0, PL_ALU, 5'd11, 5'd12, 2'b11, 5'd13, 1'b1, 32'h0000_0214);
  sample();
  check(issuer_rdy == 2'b01 && ex_valid == (pipe_bit(PlBranch) | pipe_bit(PlAlu0)),
        "instruction after jalr not held");
  flush_all();
endtask

task automatic test_raw_hazard();
  next_cycle();
  idle_inputs();
  set_slot(1'b1, PL_ALU, 5'd1, 5'd2, 2'b11, 5'd12, 1'b1, 32'h0000_0300);
  ir_valid = 2'b01;
  sample();
  check(issuer_rdy == 2'b01, "writer of x12 not issued");
  next_cycle();
  set_slot(1'b1, PL_ALU, 5'd12, 5'd0, 2'b01, 5'd13, 1'b1, 32'h0000_0304);
  repeat (3) begin
    sample();
    check(issuer_rdy == 2'b00, "reader of reserved x12 issued");
    next_cycle();
  end
  // ALU0 now has the x12 result
  fwd_act[0][12] = 1'b1;
  wait_rdy(2'b01, 3, "reader of x12 with forwarding");
  next_cycle();
  idle_inputs();
  set_slot(1'b1, PL_LS, 5'd13, 5'd0, 2'b01, 5'd0, 1'b0, 32'h0000_0308);
  ir_valid  = 2'b01;
  cmt_regwr = reg_vec_t'(1) << 13;
  sample();
  check(issuer_rdy == 2'b00, "commit cleared x13 before the clock edge");
  wait_rdy(2'b01, 3, "reader of x13 after commit");
  flush_all();
endtask

task automatic test_operand_forwarding();
  reg_data_t fwd_a;
  reg_data_t fwd_b;
  next_cycle();
  idle_inputs();
  {ira_rs1, ira_rs2, irb_rs1, irb_rs2} = {5'd3, 5'd0, 5'd17, 5'd9};
  ira_rs1_rdata = $random(seed);
  ira_rs2_rdata = $random(seed);
  irb_rs1_rdata = $random(seed);
  irb_rs2_rdata = $random(seed);
  fwd_a = $random(seed);
  fwd_b = $random(seed);
  {fwd_valid[1][0], fwd_addr[1][0], fwd_data[1][0]} = {1'b1, 5'd17, fwd_a};
  {fwd_valid[2][1], fwd_addr[2][1], fwd_data[2][1]} = {1'b1, 5'd9, fwd_b};
  // x0 must stay zero even with a matching entry
  {fwd_valid[3][0], fwd_addr[3][0], fwd_data[3][0]} = {1'b1, 5'd0, 32'hdead_beef};
  // matching address but not valid
  {fwd_addr[0][1], fwd_data[0][1]} = {5'd3, 32'h1234_5678};
  sample();
  check(ira_rs1_fwd == ira_rs1_rdata, "unmatched operand not taken from register file");
  check(ira_rs2_fwd == '0, "x0 operand not zero");
  check(irb_rs1_fwd == fwd_a && irb_rs2_fwd == fwd_b, "forwarded operand mismatch");
endtask

task automatic test_same_rd_flush();
  next_cycle();
  idle_inputs();
  set_slot(1'b1, PL_ALU, 5'd1, 5'd2, 2'b11, 5'd20, 1'b1, 32'h0000_0400);
  set_slot(1'b0, PL_MULT, 5'd3, 5'd4, 2'b11, 5'd20, 1'b1, 32'h0000_0404);
  ir_valid = 2'b11;
  sample();
  check(issuer_rdy == 2'b01 && sbd_wr_valid == 2'b01, "both writers of x20 issued at once");
  next_cycle();
  set_slot(1'b1, PL_NONE, '0, '0, 2'b00, '0, 1'b0, '0);
  ira_is0  = 1'b0;
  ir_valid = 2'b01;
  sample();
  check(issuer_rdy == 2'b01 && ex_valid == pipe_bit(PlMult), "second writer of x20 held");
  next_cycle();
  idle_inputs();
  set_slot(1'b1, PL_ALU, 5'd20, 5'd0, 2'b01, 5'd0, 1'b0, 32'h0000_0408);
  ir_valid  = 2'b01;
  cmt_flush = 1'b1;
  sample();
  check(issuer_rdy == 2'b00, "reader of reserved x20 issued");
  wait_rdy(2'b01, 3, "reader of x20 after flush");
endtask

task automatic test_back_pressure();
  next_cycle();
  idle_inputs();
  set_slot(1'b1, PL_ALU, 5'd1, 5'd2, 2'b11, 5'd25, 1'b1, 32'h0000_0500);
  ir_valid  = 2'b01;
  ex_rdy[0] = 1'b0;
  sample();
  check(issuer_rdy == 2'b00 && sbd_wr_valid == 2'b00, "alu issued while ALU0 not ready");
  next_cycle();
  ex_rdy     = '1;
  sbd_wr_rdy = 2'b00;
  sample();
  check(issuer_rdy == 2'b00, "alu issued while commit fifo not ready");
  next_cycle();
  idle_inputs();
  set_slot(1'b1, PL_ALU, 5'd25, 5'd0, 2'b01, 5'd26, 1'b1, 32'h0000_0504);
  ir_valid = 2'b01;
  sample();
  check(issuer_rdy == 2'b01, "reader of x25 blocked by a stalled writer");
  flush_all();
endtask

// ==== tb/issuer_tb.sv ====
/*
 * Directed testbench for the issue stage.
 * Drives both instruction slots, pipe ready bits, forwarding sources and
 * the commit side, then checks issue decisions, pipe selection, commit
 * FIFO writes and forwarded operands. Inputs change shortly after the
 * rising edge and outputs are sampled on the falling edge.
 */

`timescale 1ns/1ps

module issuer_tb import reg_pkg::*; import issue_pkg::*; ();

  localparam int ClkPeriod     = 40;
  localparam int DriveDly      = 2;
  localparam int NumTests      = 6;
  localparam int MaxTestCycles = 20;
  // reset plus the longest possible run of every test, with some slack
  localparam int TestCycles    = 3 + NumTests * MaxTestCycles;
  localparam int Timeout       = (TestCycles + 20) * ClkPeriod;

  logic       clk;
  logic       rst_n;
  integer     seed;
  int         n_checks;

  pl_type_e   ira_pl_type, irb_pl_type;
  reg_addr_t  ira_rs1, ira_rs2, ira_rd, irb_rs1, irb_rs2, irb_rd;
  logic [1:0] ira_ren, irb_ren;
  logic       ira_we, irb_we;
  reg_data_t  ira_pc, irb_pc;
  logic       ira_is0;
  logic [1:0] ir_valid, issuer_rdy;
  reg_data_t  ira_rs1_rdata, ira_rs2_rdata, irb_rs1_rdata, irb_rs2_rdata;
  reg_data_t  ira_rs1_fwd, ira_rs2_fwd, irb_rs1_fwd, irb_rs2_fwd;
  logic [NumExPl-2:0]                         ex_rdy;
  pl_sel_t                                    ex_valid;
  logic      [NumFwdSrc-1:0][NumFwdPort-1:0]  fwd_valid;
  reg_addr_t [NumFwdSrc-1:0][NumFwdPort-1:0]  fwd_addr;
  reg_data_t [NumFwdSrc-1:0][NumFwdPort-1:0]  fwd_data;
  reg_vec_t  [NumFwdSrc-1:0]                  fwd_act;
  reg_vec_t   cmt_regwr;
  logic       cmt_flush;
  logic [1:0] sbd_wr_rdy, sbd_wr_valid;
  pl_sel_t    sbd_wdata0_pl, sbd_wdata1_pl;
  reg_data_t  sbd_wdata0_pc, sbd_wdata1_pc;

  issuer DUT (
    .clk_i (clk), .rst_ni (rst_n),
    .ira_pl_type_i (ira_pl_type), .ira_rs1_i (ira_rs1), .ira_rs2_i (ira_rs2),
    .ira_ren_i (ira_ren), .ira_rd_i (ira_rd), .ira_we_i (ira_we), .ira_pc_i (ira_pc),
    .irb_pl_type_i (irb_pl_type), .irb_rs1_i (irb_rs1), .irb_rs2_i (irb_rs2),
    .irb_ren_i (irb_ren), .irb_rd_i (irb_rd), .irb_we_i (irb_we), .irb_pc_i (irb_pc),
    .ira_is0_i (ira_is0), .ir_valid_i (ir_valid), .issuer_rdy_o (issuer_rdy),
    .ira_rs1_rdata_i (ira_rs1_rdata), .ira_rs2_rdata_i (ira_rs2_rdata),
    .irb_rs1_rdata_i (irb_rs1_rdata), .irb_rs2_rdata_i (irb_rs2_rdata),
    .ira_rs1_fwd_rdata_o (ira_rs1_fwd), .ira_rs2_fwd_rdata_o (ira_rs2_fwd),
    .irb_rs1_fwd_rdata_o (irb_rs1_fwd), .irb_rs2_fwd_rdata_o (irb_rs2_fwd),
    .ex_rdy_i (ex_rdy), .ex_valid_o (ex_valid), .fwd_valid_i (fwd_valid),
    .fwd_addr_i (fwd_addr), .fwd_data_i (fwd_data), .fwd_act_i (fwd_act),
    .cmt_regwr_i (cmt_regwr), .cmt_flush_i (cmt_flush), .sbd_wr_rdy_i (sbd_wr_rdy),
    .sbd_wr_valid_o (sbd_wr_valid), .sbd_wdata0_pl_o (sbd_wdata0_pl),
    .sbd_wdata0_pc_o (sbd_wdata0_pc), .sbd_wdata1_pl_o (sbd_wdata1_pl),
    .sbd_wdata1_pc_o (sbd_wdata1_pc)
  );

  task automatic report_error(input string line);
    $display("%s", line);
    $display("Result: FAILED");
    $fatal(1, "simulation stopped after the first error");
  endtask

  task automatic check(input bit cond, input string msg);
    n_checks++;
    assert (cond) else report_error($sformatf("FAIL @ %0t ns: %s", $time, msg));
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #DriveDly;
  endtask

  task automatic sample();
    @(negedge clk);
  endtask

  function automatic pl_sel_t pipe_bit(input int unsigned idx);
    return pl_sel_t'(1) << idx;
  endfunction

  task automatic set_slot(input bit slot_a, input pl_type_e pl_type, input reg_addr_t rs1,
                          input reg_addr_t rs2, input logic [1:0] ren, input reg_addr_t rd,
                          input logic we, input reg_data_t pc);
    if (slot_a) begin
      ira_pl_type = pl_type;
      {ira_rs1, ira_rs2, ira_ren, ira_rd, ira_we, ira_pc} = {rs1, rs2, ren, rd, we, pc};
    end else begin
      irb_pl_type = pl_type;
      {irb_rs1, irb_rs2, irb_ren, irb_rd, irb_we, irb_pc} = {rs1, rs2, ren, rd, we, pc};
    end
  endtask

  // no instruction offered, every pipe ready, nothing forwarded or committed
  task automatic idle_inputs();
    set_slot(1'b1, PL_NONE, '0, '0, 2'b00, '0, 1'b0, '0);
    set_slot(1'b0, PL_NONE, '0, '0, 2'b00, '0, 1'b0, '0);
    ira_is0    = 1'b1;
    ir_valid   = 2'b00;
    {ira_rs1_rdata, ira_rs2_rdata, irb_rs1_rdata, irb_rs2_rdata} = '0;
    ex_rdy     = '1;
    sbd_wr_rdy = 2'b11;
    fwd_valid  = '0;
    fwd_addr   = '0;
    fwd_data   = '0;
    fwd_act    = '0;
    cmt_regwr  = '0;
    cmt_flush  = 1'b0;
  endtask

  // the handshake is combinational, so each sample is a fresh decision
  task automatic wait_rdy(input logic [1:0] mask, input int max_cycles, input string what);
    int n;
    n = 0;
    sample();
    while ((issuer_rdy & mask) != mask) begin
      if (n >= max_cycles) begin
        report_error($sformatf("%s did not issue within %0d cycles", what, max_cycles));
      end else begin
        n++;
        next_cycle();
        sample();
      end
    end
  endtask

  task automatic flush_all();
    next_cycle();
    idle_inputs();
    cmt_flush = 1'b1;
    next_cycle();
    cmt_flush = 1'b0;
  endtask

  `include "issuer_tests.svh"

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  initial begin
    #(Timeout);
    report_error("watchdog timeout, the test sequence did not finish in time");
  end

  initial begin
    seed     = 51;
    n_checks = 0;
    rst_n    = 1'b0;
    idle_inputs();
    repeat (3) @(posedge clk);
    #DriveDly;
    rst_n = 1'b1;
    sample();
    check(issuer_rdy == 2'b00 && ex_valid == '0 && sbd_wr_valid == 2'b00,
          "control outputs not idle after reset");
    test_single_issue();
    test_pair_rules();
    test_raw_hazard();
    test_operand_forwarding();
    test_same_rd_flush();
    test_back_pressure();
    if (n_checks > 0) begin
      $display("Result: PASSED");
      $finish;
    end else begin
      report_error("no checks were executed");
    end
  end

endmodule

// ==== verilog/issue_pkg.sv ====
/*
 * Issue-stage definitions for pipeline selection and forwarding.
 * pl_type_e is the pipeline class from the decoder. A pipe-select vector
 * has one bit per execution pipe, the branch unit in bit 0. Forwarding
 * sources are the four execution pipes, each with two result ports.
 */

package issue_pkg;

  // pipeline class of a decoded instruction
  typedef enum logic [2:0] {
    PL_NONE   = 3'd0,
    PL_ALU    = 3'd1,
    PL_LS     = 3'd2,
    PL_MULT   = 3'd3,
    PL_BRANCH = 3'd4,
    PL_JAL    = 3'd5,
    PL_JALR   = 3'd6
  } pl_type_e;

  // execution pipes, branch unit included
  localparam int unsigned NumExPl = 5;

  // bit positions in a pipe-select vector
  localparam int unsigned PlBranch = 0;
  localparam int unsigned PlAlu0   = 1;
  localparam int unsigned PlAlu1   = 2;
  localparam int unsigned PlLs     = 3;
  localparam int unsigned PlMult   = 4;

  typedef logic [NumExPl-1:0] pl_sel_t;

  // forwarding pipes in order ALU0, ALU1, LS, MULT
  localparam int unsigned NumFwdSrc  = 4;
  localparam int unsigned NumFwdPort = 2;

endpackage

// ==== verilog/issuer.sv ====
/*
 * Issue stage of the dual-issue in-order core.
 * Slots a and b arrive with a flag that marks which one is older. They are
 * put into age order for pipe selection and hazard checks, while operand
 * forwarding works on the slots directly. All outputs are combinational
 * from the inputs and the reservation state.
 */

`timescale 1ns/1ps

module issuer import reg_pkg::*; import issue_pkg::*; #(
  parameter bit DualIssue = 1'b1,
  parameter bit AllowWaW  = 1'b1
) (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,

  // decoded instructions, slot a
  input  pl_type_e                                ira_pl_type_i,
  input  reg_addr_t                               ira_rs1_i,
  input  reg_addr_t                               ira_rs2_i,
  input  logic      [1:0]                         ira_ren_i,
  input  reg_addr_t                               ira_rd_i,
  input  logic                                    ira_we_i,
  input  reg_data_t                               ira_pc_i,
  // slot b
  input  pl_type_e                                irb_pl_type_i,
  input  reg_addr_t                               irb_rs1_i,
  input  reg_addr_t                               irb_rs2_i,
  input  logic      [1:0]                         irb_ren_i,
  input  reg_addr_t                               irb_rd_i,
  input  logic                                    irb_we_i,
  input  reg_data_t                               irb_pc_i,

  input  logic                                    ira_is0_i,
  input  logic      [1:0]                         ir_valid_i,
  output logic      [1:0]                         issuer_rdy_o,

  // register file read data and forwarded operands
  input  reg_data_t                               ira_rs1_rdata_i,
  input  reg_data_t                               ira_rs2_rdata_i,
  input  reg_data_t                               irb_rs1_rdata_i,
  input  reg_data_t                               irb_rs2_rdata_i,
  output reg_data_t                               ira_rs1_fwd_rdata_o,
  output reg_data_t                               ira_rs2_fwd_rdata_o,
  output reg_data_t                               irb_rs1_fwd_rdata_o,
  output reg_data_t                               irb_rs2_fwd_rdata_o,

  // execution pipes
  input  logic      [NumExPl-2:0]                 ex_rdy_i,
  output pl_sel_t                                 ex_valid_o,
  input  logic      [NumFwdSrc-1:0][NumFwdPort-1:0] fwd_valid_i,
  input  reg_addr_t [NumFwdSrc-1:0][NumFwdPort-1:0] fwd_addr_i,
  input  reg_data_t [NumFwdSrc-1:0][NumFwdPort-1:0] fwd_data_i,
  input  reg_vec_t  [NumFwdSrc-1:0]               fwd_act_i,

  // commit side
  input  reg_vec_t                                cmt_regwr_i,
  input  logic                                    cmt_flush_i,
  input  logic      [1:0]                         sbd_wr_rdy_i,
  output logic      [1:0]                         sbd_wr_valid_o,
  output pl_sel_t                                 sbd_wdata0_pl_o,
  output reg_data_t                               sbd_wdata0_pc_o,
  output pl_sel_t                                 sbd_wdata1_pl_o,
  output reg_data_t                               sbd_wdata1_pc_o
);

  pl_type_e   ir0_pl_type, ir1_pl_type;
  reg_addr_t  ir0_rs1, ir0_rs2, ir0_rd, ir1_rs1, ir1_rs2, ir1_rd;
  logic [1:0] ir0_ren, ir1_ren;
  logic       ir0_we, ir1_we;
  reg_data_t  ir0_pc, ir1_pc;
  logic [1:0] ir_hazard, ir_issued;

  // age order, ir0 is the older instruction
  assign ir0_pl_type = ira_is0_i ? ira_pl_type_i : irb_pl_type_i;
  assign ir1_pl_type = ira_is0_i ? irb_pl_type_i : ira_pl_type_i;
  assign ir0_rs1     = ira_is0_i ? ira_rs1_i : irb_rs1_i;
  assign ir1_rs1     = ira_is0_i ? irb_rs1_i : ira_rs1_i;
  assign ir0_rs2     = ira_is0_i ? ira_rs2_i : irb_rs2_i;
  assign ir1_rs2     = ira_is0_i ? irb_rs2_i : ira_rs2_i;
  assign ir0_ren     = ira_is0_i ? ira_ren_i : irb_ren_i;
  assign ir1_ren     = ira_is0_i ? irb_ren_i : ira_ren_i;
  assign ir0_rd      = ira_is0_i ? ira_rd_i : irb_rd_i;
  assign ir1_rd      = ira_is0_i ? irb_rd_i : ira_rd_i;
  assign ir0_we      = ira_is0_i ? ira_we_i : irb_we_i;
  assign ir1_we      = ira_is0_i ? irb_we_i : ira_we_i;
  assign ir0_pc      = ira_is0_i ? ira_pc_i : irb_pc_i;
  assign ir1_pc      = ira_is0_i ? irb_pc_i : ira_pc_i;

  pipe_select #(
    .DualIssue (DualIssue)
  ) u_pipe_select (
    .clk_i, .rst_ni, .ira_is0_i, .ir_valid_i,
    .ir0_pl_type_i (ir0_pl_type),
    .ir1_pl_type_i (ir1_pl_type),
    .ir0_pc_i      (ir0_pc),
    .ir1_pc_i      (ir1_pc),
    .ir_hazard_i   (ir_hazard),
    .ex_rdy_i, .sbd_wr_rdy_i,
    .ir_issued_o   (ir_issued),
    .issuer_rdy_o, .ex_valid_o, .sbd_wr_valid_o,
    .sbd_wdata0_pl_o, .sbd_wdata0_pc_o, .sbd_wdata1_pl_o, .sbd_wdata1_pc_o
  );

  reg_reserve #(
    .AllowWaW (AllowWaW)
  ) u_reg_reserve (
    .clk_i, .rst_ni,
    .ir0_rs1_i (ir0_rs1), .ir0_rs2_i (ir0_rs2), .ir0_ren_i (ir0_ren),
    .ir0_rd_i  (ir0_rd),  .ir0_we_i  (ir0_we),
    .ir1_rs1_i (ir1_rs1), .ir1_rs2_i (ir1_rs2), .ir1_ren_i (ir1_ren),
    .ir1_rd_i  (ir1_rd),  .ir1_we_i  (ir1_we),
    .ir_issued_i (ir_issued),
    .fwd_act_i, .cmt_regwr_i, .cmt_flush_i,
    .ir_hazard_o (ir_hazard)
  );

  operand_fwd u_operand_fwd (
    .ira_rs1_i, .ira_rs2_i, .irb_rs1_i, .irb_rs2_i,
    .ira_rs1_rdata_i, .ira_rs2_rdata_i, .irb_rs1_rdata_i, .irb_rs2_rdata_i,
    .fwd_valid_i, .fwd_addr_i, .fwd_data_i,
    .ira_rs1_fwd_rdata_o, .ira_rs2_fwd_rdata_o,
    .irb_rs1_fwd_rdata_o, .irb_rs2_fwd_rdata_o
  );

endmodule

// ==== verilog/operand_fwd.sv ====
/*
 * Operand forwarding for the rs1/rs2 operands of slots a and b.
 * A valid forwarding entry with a matching address overrides the
 * register-file data, otherwise the register-file value passes on.
 * x0 always reads as zero.
 */

`timescale 1ns/1ps

module operand_fwd import reg_pkg::*; import issue_pkg::*; (
  input  reg_addr_t                               ira_rs1_i,
  input  reg_addr_t                               ira_rs2_i,
  input  reg_addr_t                               irb_rs1_i,
  input  reg_addr_t                               irb_rs2_i,

  input  reg_data_t                               ira_rs1_rdata_i,
  input  reg_data_t                               ira_rs2_rdata_i,
  input  reg_data_t                               irb_rs1_rdata_i,
  input  reg_data_t                               irb_rs2_rdata_i,

  input  logic      [NumFwdSrc-1:0][NumFwdPort-1:0] fwd_valid_i,
  input  reg_addr_t [NumFwdSrc-1:0][NumFwdPort-1:0] fwd_addr_i,
  input  reg_data_t [NumFwdSrc-1:0][NumFwdPort-1:0] fwd_data_i,

  output reg_data_t                               ira_rs1_fwd_rdata_o,
  output reg_data_t                               ira_rs2_fwd_rdata_o,
  output reg_data_t                               irb_rs1_fwd_rdata_o,
  output reg_data_t                               irb_rs2_fwd_rdata_o
);

  // look up one operand across all pipes and result ports
  function automatic reg_data_t fwd_lookup(
    reg_addr_t                                 raddr,
    reg_data_t                                 rf_rdata,
    logic      [NumFwdSrc-1:0][NumFwdPort-1:0] valid,
    reg_addr_t [NumFwdSrc-1:0][NumFwdPort-1:0] addr,
    reg_data_t [NumFwdSrc-1:0][NumFwdPort-1:0] data
  );
    reg_data_t result;
    reg_data_t fwd_data;
    logic      hit;
    fwd_data = '0;
    hit      = 1'b0;
    for (int s = 0; s < NumFwdSrc; s++) begin
      for (int p = 0; p < NumFwdPort; p++) begin
        if (valid[s][p] && (addr[s][p] == raddr)) begin
          fwd_data = fwd_data | data[s][p];
          hit      = 1'b1;
        end
      end
    end
    if (raddr == '0)
      result = '0;
    else if (hit)
      result = fwd_data;
    else
      result = rf_rdata;
    return result;
  endfunction

  assign ira_rs1_fwd_rdata_o = fwd_lookup(ira_rs1_i, ira_rs1_rdata_i,
                                          fwd_valid_i, fwd_addr_i, fwd_data_i);
  assign ira_rs2_fwd_rdata_o = fwd_lookup(ira_rs2_i, ira_rs2_rdata_i,
                                          fwd_valid_i, fwd_addr_i, fwd_data_i);
  assign irb_rs1_fwd_rdata_o = fwd_lookup(irb_rs1_i, irb_rs1_rdata_i,
                                          fwd_valid_i, fwd_addr_i, fwd_data_i);
  assign irb_rs2_fwd_rdata_o = fwd_lookup(irb_rs2_i, irb_rs2_rdata_i,
                                          fwd_valid_i, fwd_addr_i, fwd_data_i);

endmodule

// ==== verilog/pipe_select.sv ====
/*
 * Pipeline selection and issue decision for two age-ordered instructions.
 * ir0 is the older one. Each instruction is mapped onto execution pipes.
 * ir1 only goes when ir0 goes and does not collide with ir0's pipes.
 * Issued instructions other than pure branches are written to the
 * commit scoreboard FIFO. Purely combinational apart from the checks.
 */

`timescale 1ns/1ps

module pipe_select import reg_pkg::*; import issue_pkg::*; #(
  parameter bit DualIssue = 1'b1
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,

  input  logic                 ira_is0_i,
  input  logic [1:0]           ir_valid_i,
  input  pl_type_e             ir0_pl_type_i,
  input  pl_type_e             ir1_pl_type_i,
  input  reg_data_t            ir0_pc_i,
  input  reg_data_t            ir1_pc_i,
  input  logic [1:0]           ir_hazard_i,
  input  logic [NumExPl-2:0]   ex_rdy_i,
  input  logic [1:0]           sbd_wr_rdy_i,

  output logic [1:0]           ir_issued_o,
  output logic [1:0]           issuer_rdy_o,
  output pl_sel_t              ex_valid_o,
  output logic [1:0]           sbd_wr_valid_o,
  output pl_sel_t              sbd_wdata0_pl_o,
  output reg_data_t            sbd_wdata0_pc_o,
  output pl_sel_t              sbd_wdata1_pl_o,
  output reg_data_t            sbd_wdata1_pc_o
);

  // drop the branch-unit bit and keep the execution pipes
  function automatic pl_sel_t ex_only(pl_sel_t sel);
    pl_sel_t result;
    result           = sel;
    result[PlBranch] = 1'b0;
    return result;
  endfunction

  // map a pipeline class onto pipes
  // slot a uses ALU0 and slot b uses ALU1
  function automatic pl_sel_t select_pl(logic enable, logic from_a, pl_type_e pl_type);
    pl_sel_t result;
    result = '0;
    if (enable) begin
      case (pl_type)
        PL_JAL, PL_JALR: begin
          result[PlBranch] = 1'b1;
          result[from_a ? PlAlu0 : PlAlu1] = 1'b1;
        end
        PL_BRANCH: result[PlBranch] = 1'b1;
        PL_ALU:    result[from_a ? PlAlu0 : PlAlu1] = 1'b1;
        PL_LS:     result[PlLs] = 1'b1;
        PL_MULT:   result[PlMult] = 1'b1;
        default:   result = '0;
      endcase
    end
    return result;
  endfunction

  // the branch unit always accepts while other pipes need one ready bit
  function automatic logic is_issued(pl_sel_t sel, pl_sel_t rdy);
    logic result;
    if (|ex_only(sel))
      result = |(ex_only(sel) & rdy);
    else
      result = sel[PlBranch];
    return result;
  endfunction

  pl_sel_t    ex_rdy;
  pl_sel_t    ir0_sel, ir1_sel;
  logic [1:0] ir_en;
  logic [1:0] ir_issued;
  logic [1:0] fifo_wr;

  assign ex_rdy = {ex_rdy_i, 1'b1};

  assign ir_en[0] = ir_valid_i[0] & ~ir_hazard_i[0] & sbd_wr_rdy_i[0];
  assign ir0_sel  = select_pl(ir_en[0], ira_is0_i, ir0_pl_type_i);

  // jalr redirects fetch so the younger instruction has to wait
  assign ir_en[1] = DualIssue & ir_issued[0] & ir_valid_i[1] & ~ir_hazard_i[1] &
                    (ir0_pl_type_i != PL_JALR) & sbd_wr_rdy_i[1];
  assign ir1_sel  = select_pl(ir_en[1], ~ira_is0_i, ir1_pl_type_i) & ~ex_only(ir0_sel);

  assign ir_issued[0] = is_issued(ir0_sel, ex_rdy);
  assign ir_issued[1] = is_issued(ir1_sel, ex_rdy);

  assign ir_issued_o  = ir_issued;
  assign issuer_rdy_o = ir_issued;
  assign ex_valid_o   = ir0_sel | ir1_sel;

  // branches retire in the branch unit and skip the commit FIFO
  assign fifo_wr[0] = ir_issued[0] & (|ex_only(ir0_sel));
  assign fifo_wr[1] = ir_issued[1] & (|ex_only(ir1_sel));

  assign sbd_wr_valid_o[0] = |fifo_wr;
  assign sbd_wr_valid_o[1] = &fifo_wr;
  assign sbd_wdata0_pl_o   = fifo_wr[0] ? ir0_sel : ir1_sel;
  assign sbd_wdata0_pc_o   = fifo_wr[0] ? ir0_pc_i : ir1_pc_i;
  assign sbd_wdata1_pl_o   = ir1_sel;
  assign sbd_wdata1_pc_o   = ir1_pc_i;

  // the younger instruction never issues ahead of the older one
  a_ir1_after_ir0: assert property (
    @(posedge clk_i) disable iff (!rst_ni) ir_issued[1] |-> ir_issued[0]
  ) else $error("ir1 issued without ir0");

  // an issued ir1 asked for no execution pipe that ir0 already holds
  a_no_pipe_share: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    ir_issued[1] |->
      ~|(ex_only(ir0_sel) & ex_only(select_pl(1'b1, ~ira_is0_i, ir1_pl_type_i)))
  ) else $error("ir0 and ir1 selected the same execution pipe");

endmodule

// ==== verilog/reg_pkg.sv ====
/*
 * Register-file definitions shared by the issue stage.
 * Holds the architectural register count, the address and operand widths
 * and the one-bit-per-register vector used by the reservation scoreboard,
 * the commit write-back mask and the forwarding-active masks.
 * Import it wherever register indices or operand data are handled.
 */

package reg_pkg;

  // architectural register file
  localparam int unsigned NumRegs  = 32;
  localparam int unsigned RegAddrW = 5;
  localparam int unsigned RegDataW = 32;

  // register index as decoded from rs1/rs2/rd
  typedef logic [RegAddrW-1:0] reg_addr_t;

  // operand value, also used for the instruction PC
  typedef logic [RegDataW-1:0] reg_data_t;

  // one bit per register, bit 0 (x0) is never set
  typedef logic [NumRegs-1:0] reg_vec_t;

endpackage

// ==== verilog/reg_reserve.sv ====
/*
 * Register reservation scoreboard of the issue stage.
 * An issued instruction that writes rd reserves that register until the
 * commit side reports the write-back or a flush clears everything.
 * Reads of a reserved register stall unless a pipe can forward it, and
 * with AllowWaW cleared a write to a reserved register stalls as well.
 */

`timescale 1ns/1ps

module reg_reserve import reg_pkg::*; import issue_pkg::*; #(
  parameter bit AllowWaW = 1'b1
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,

  input  reg_addr_t             ir0_rs1_i,
  input  reg_addr_t             ir0_rs2_i,
  input  logic [1:0]            ir0_ren_i,
  input  reg_addr_t             ir0_rd_i,
  input  logic                  ir0_we_i,

  input  reg_addr_t             ir1_rs1_i,
  input  reg_addr_t             ir1_rs2_i,
  input  logic [1:0]            ir1_ren_i,
  input  reg_addr_t             ir1_rd_i,
  input  logic                  ir1_we_i,

  input  logic [1:0]            ir_issued_i,
  input  reg_vec_t [NumFwdSrc-1:0] fwd_act_i,
  input  reg_vec_t              cmt_regwr_i,
  input  logic                  cmt_flush_i,

  output logic [1:0]            ir_hazard_o
);

  // one-hot register request, x0 never requests anything
  function automatic reg_vec_t reg_req(reg_addr_t addr, logic en);
    reg_vec_t result;
    result = '0;
    if (en && (addr != '0))
      result[addr] = 1'b1;
    return result;
  endfunction

  reg_vec_t rsv_q;
  reg_vec_t rsv_set;
  reg_vec_t fwd_all, ir1_fwd;
  reg_vec_t ir0_rd_req, ir0_wr_req, ir1_rd_req, ir1_wr_req;
  reg_vec_t ir0_waw_st, ir0_raw_st, ir1_waw_st, ir1_raw_st;
  logic     wr_conflict;

  assign ir0_rd_req = reg_req(ir0_rs1_i, ir0_ren_i[0]) | reg_req(ir0_rs2_i, ir0_ren_i[1]);
  assign ir1_rd_req = reg_req(ir1_rs1_i, ir1_ren_i[0]) | reg_req(ir1_rs2_i, ir1_ren_i[1]);
  assign ir0_wr_req = reg_req(ir0_rd_i, ir0_we_i);
  assign ir1_wr_req = reg_req(ir1_rd_i, ir1_we_i);

  // registers that some pipe can forward this cycle
  always_comb begin
    fwd_all = '0;
    for (int s = 0; s < NumFwdSrc; s++) begin
      fwd_all = fwd_all | fwd_act_i[s];
    end
  end

  // ir1 sees ir0's target as already reserved
  // with WaW allowed, an older forward of that register is stale for ir1
  assign ir1_fwd    = AllowWaW ? (fwd_all & ~ir0_wr_req) : fwd_all;

  assign ir0_waw_st = rsv_q;
  assign ir0_raw_st = ir0_waw_st & ~fwd_all;
  assign ir1_waw_st = rsv_q | ir0_wr_req;
  assign ir1_raw_st = ir1_waw_st & ~ir1_fwd;

  // same rd in both slots has to go one at a time
  assign wr_conflict = |(ir0_wr_req & ir1_wr_req);

  assign ir_hazard_o[0] = (|(ir0_raw_st & ir0_rd_req)) |
                          (~AllowWaW & (|(ir0_waw_st & ir0_wr_req)));
  assign ir_hazard_o[1] = (|(ir1_raw_st & ir1_rd_req)) |
                          (~AllowWaW & (|(ir1_waw_st & ir1_wr_req))) | wr_conflict;

  assign rsv_set = ({NumRegs{ir_issued_i[0]}} & ir0_wr_req) |
                   ({NumRegs{ir_issued_i[1]}} & ir1_wr_req);

  // a new reservation beats a commit to the same register
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rsv_q <= '0;
    end else if (cmt_flush_i) begin
      rsv_q <= '0;
    end else begin
      rsv_q <= (rsv_q & ~cmt_regwr_i) | rsv_set;
    end
  end

  // x0 is hardwired, so it can never be reserved
  a_x0_free: assert property (
    @(posedge clk_i) disable iff (!rst_ni) !rsv_q[0]
  ) else $error("reservation set on register x0");

endmodule
